/* run_sim.sh */
#!/usr/bin/env bash
# Builds the CDC link testbench with Verilator and runs it.
# The exit status is 0 only when the testbench reports a pass.
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_cdc_link

verilator --binary --timing --assert -j 0 --top-module "${TOP}" -f sim.f
build_status=$?
if [ ${build_status} -ne 0 ]; then
  echo "Verilator build failed with status ${build_status}"
  exit 1
fi

sim_out=$(./obj_dir/V${TOP} 2>&1)
sim_status=$?
echo "${sim_out}"
if [ ${sim_status} -ne 0 ]; then
  echo "Simulation exited with status ${sim_status}"
  exit 1
fi

if echo "${sim_out}" | grep -qx "TB PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* sim.f */
source/cdc_link_pkg.sv
source/cdc_2phase.sv
source/cdc_fifo_2phase.sv
source/src_spill_reg.sv
source/dst_out_reg.sv
source/cdc_link_top.sv
verification/tb_clock_gen.sv
verification/tb_cdc_link.sv

/* source/cdc_2phase.sv */
// ----------------------------------------------------------------------
// 2-phase toggle handshake synchronizer for one FIFO pointer
// The source value is sampled whenever no request is in flight and
// shows up on the destination side a few cycles later
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cdc_2phase (
  input  logic                src_clk_i,
  input  logic                src_rst_ni,
  input  logic                dst_clk_i,
  input  logic                dst_rst_ni,
  input  cdc_link_pkg::ptr_t  src_ptr_i,
  output cdc_link_pkg::ptr_t  dst_ptr_o
);

  import cdc_link_pkg::*;

  // Source domain state
  logic       req_src_q;
  ptr_t       data_src_q;
  logic [1:0] ack_sync_q;
  logic       src_pending;

  // Destination domain state
  logic [1:0] req_sync_q;
  logic       ack_dst_q;
  ptr_t       dst_ptr_q;
  logic       dst_new_req;

  // A request is open until the acknowledge toggle has come back
  assign src_pending = req_src_q ^ ack_sync_q[1];

  // Capture the running pointer and toggle req once the last one is done
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      req_src_q  <= 1'b0;
      data_src_q <= '0;
    end else if (!src_pending) begin
      req_src_q  <= ~req_src_q;
      data_src_q <= src_ptr_i;
    end
  end

  // Bring ack back into the source domain through two flops
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      ack_sync_q <= 2'b00;
    end else begin
      ack_sync_q <= {ack_sync_q[0], ack_dst_q};
    end
  end

  // Bring req into the destination domain through two flops
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      req_sync_q <= 2'b00;
    end else begin
      req_sync_q <= {req_sync_q[0], req_src_q};
    end
  end

  // A toggle that ack has not followed yet means fresh data is waiting
  assign dst_new_req = req_sync_q[1] ^ ack_dst_q;

  // Latch the held source value and answer with an ack toggle
  // data_src_q is quiet here because the source waits for this ack
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      ack_dst_q <= 1'b0;
      dst_ptr_q <= '0;
    end else if (dst_new_req) begin
      ack_dst_q <= ~ack_dst_q;
      dst_ptr_q <= data_src_q;
    end
  end

  assign dst_ptr_o = dst_ptr_q;

  // The value crossing the boundary must hold while the far side takes it
  a_src_data_held : assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    dst_new_req |-> $stable(data_src_q)
  );

endmodule

/* source/cdc_fifo_2phase.sv */
// ----------------------------------------------------------------------
// Dual-clock FIFO with binary pointers sent across by 2-phase handshakes
// Writes happen in the source domain and reads come combinationally
// from the memory in the destination domain
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cdc_fifo_2phase (
  input  logic                   src_clk_i,
  input  logic                   src_rst_ni,
  input  logic                   dst_clk_i,
  input  logic                   dst_rst_ni,
  input  cdc_link_pkg::payload_t src_data_i,
  input  logic                   src_valid_i,
  output logic                   src_ready_o,
  output cdc_link_pkg::payload_t dst_data_o,
  output logic                   dst_valid_o,
  input  logic                   dst_ready_i
);

  import cdc_link_pkg::*;

  // Storage that only the source clock writes
  payload_t fifo_data_q [FIFO_DEPTH];

  // Local pointers and their delayed copies from the other domain
  ptr_t src_wptr_q;
  ptr_t src_rptr;
  ptr_t dst_rptr_q;
  ptr_t dst_wptr;

  idx_t fifo_widx;
  idx_t fifo_ridx;
  logic fifo_write;
  logic fifo_read;
  logic src_full;
  logic dst_empty;

  assign fifo_widx = src_wptr_q[LOG_DEPTH-1:0];
  assign fifo_ridx = dst_rptr_q[LOG_DEPTH-1:0];

  // Full means same index but opposite wrap bit
  // The read pointer seen here lags so full can linger a bit too long
  assign src_full = (src_wptr_q[LOG_DEPTH] != src_rptr[LOG_DEPTH]) &&
                    (fifo_widx == src_rptr[LOG_DEPTH-1:0]);

  // Empty means both pointers equal, also judged from a lagging copy
  assign dst_empty = (dst_wptr == dst_rptr_q);

  assign src_ready_o = !src_full;
  assign dst_valid_o = !dst_empty;

  assign fifo_write = src_valid_i && src_ready_o;
  assign fifo_read  = dst_valid_o && dst_ready_i;

  always_ff @(posedge src_clk_i) begin
    if (fifo_write) begin
      fifo_data_q[fifo_widx] <= src_data_i;
    end
  end

  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_wptr_q <= '0;
    end else if (fifo_write) begin
      src_wptr_q <= src_wptr_q + ptr_t'(1);
    end
  end

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_rptr_q <= '0;
    end else if (fifo_read) begin
      dst_rptr_q <= dst_rptr_q + ptr_t'(1);
    end
  end

  // Head of the queue straight out of the memory
  assign dst_data_o = fifo_data_q[fifo_ridx];

  // Write pointer goes from source to destination
  cdc_2phase i_cdc_wptr (
    .src_clk_i  (src_clk_i),
    .src_rst_ni (src_rst_ni),
    .dst_clk_i  (dst_clk_i),
    .dst_rst_ni (dst_rst_ni),
    .src_ptr_i  (src_wptr_q),
    .dst_ptr_o  (dst_wptr)
  );

  // Read pointer goes the other way round
  cdc_2phase i_cdc_rptr (
    .src_clk_i  (dst_clk_i),
    .src_rst_ni (dst_rst_ni),
    .dst_clk_i  (src_clk_i),
    .dst_rst_ni (src_rst_ni),
    .src_ptr_i  (dst_rptr_q),
    .dst_ptr_o  (src_rptr)
  );

  // No write while full shows as the source occupancy never passing the depth
  a_no_write_full : assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    ptr_t'(src_wptr_q - src_rptr) <= ptr_t'(FIFO_DEPTH)
  );

  // No read while empty keeps the read pointer from overtaking the write one
  a_no_read_empty : assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    ptr_t'(dst_wptr - dst_rptr_q) <= ptr_t'(FIFO_DEPTH)
  );

endmodule

/* source/cdc_link_pkg.sv */
// ----------------------------------------------------------------------
// Shared types and constants for the clock-domain-crossing link
// Every RTL module and the testbench import from here
// ----------------------------------------------------------------------

package cdc_link_pkg;

  // Payload field widths
  localparam int DATA_WIDTH = 32;
  localparam int TAG_WIDTH  = 4;

  // One word as it travels through the link, tag in the upper bits
  typedef struct packed {
    logic [TAG_WIDTH-1:0]  tag;
    logic [DATA_WIDTH-1:0] data;
  } payload_t;

  // The FIFO holds 2**LOG_DEPTH words
  localparam int LOG_DEPTH  = 3;
  localparam int FIFO_DEPTH = 2 ** LOG_DEPTH;

  // Pointers carry one extra wrap bit on top of the memory index
  typedef logic [LOG_DEPTH:0]   ptr_t;
  typedef logic [LOG_DEPTH-1:0] idx_t;

  // Words held when the destination stalls
  // Two in the spill register, the FIFO and one in the output register
  localparam int LINK_CAPACITY = 2 + FIFO_DEPTH + 1;

  // Fill level of the source-side spill register
  typedef enum logic [1:0] {
    SPILL_EMPTY,
    SPILL_ONE,
    SPILL_TWO
  } spill_state_e;

endpackage

/* source/cdc_link_top.sv */
// ----------------------------------------------------------------------
// Top level of the clock-domain-crossing link
// Spill register, dual-clock FIFO and output register in a chain
// Both resets are expected to be applied together
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cdc_link_top (
  input  logic                   src_clk_i,
  input  logic                   src_rst_ni,
  input  cdc_link_pkg::payload_t src_data_i,
  input  logic                   src_valid_i,
  output logic                   src_ready_o,
  input  logic                   dst_clk_i,
  input  logic                   dst_rst_ni,
  output cdc_link_pkg::payload_t dst_data_o,
  output logic                   dst_valid_o,
  input  logic                   dst_ready_i
);

  import cdc_link_pkg::*;

  // Stream from the spill register into the FIFO
  payload_t spl_data;
  logic     spl_valid;
  logic     spl_ready;

  // Stream from the FIFO into the output register
  payload_t fifo_data;
  logic     fifo_valid;
  logic     fifo_ready;

  src_spill_reg i_spill (
    .src_clk_i   (src_clk_i),
    .src_rst_ni  (src_rst_ni),
    .in_data_i   (src_data_i),
    .in_valid_i  (src_valid_i),
    .in_ready_o  (src_ready_o),
    .out_data_o  (spl_data),
    .out_valid_o (spl_valid),
    .out_ready_i (spl_ready)
  );

  cdc_fifo_2phase i_fifo (
    .src_clk_i   (src_clk_i),
    .src_rst_ni  (src_rst_ni),
    .dst_clk_i   (dst_clk_i),
    .dst_rst_ni  (dst_rst_ni),
    .src_data_i  (spl_data),
    .src_valid_i (spl_valid),
    .src_ready_o (spl_ready),
    .dst_data_o  (fifo_data),
    .dst_valid_o (fifo_valid),
    .dst_ready_i (fifo_ready)
  );

  dst_out_reg i_out (
    .dst_clk_i   (dst_clk_i),
    .dst_rst_ni  (dst_rst_ni),
    .in_data_i   (fifo_data),
    .in_valid_i  (fifo_valid),
    .in_ready_o  (fifo_ready),
    .out_data_o  (dst_data_o),
    .out_valid_o (dst_valid_o),
    .out_ready_i (dst_ready_i)
  );

endmodule

/* source/dst_out_reg.sv */
// ----------------------------------------------------------------------
// One-entry output register in the destination domain
// Puts a flop between the FIFO memory and the outgoing data
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module dst_out_reg (
  input  logic                   dst_clk_i,
  input  logic                   dst_rst_ni,
  input  cdc_link_pkg::payload_t in_data_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output cdc_link_pkg::payload_t out_data_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i
);

  import cdc_link_pkg::*;

  payload_t data_q;
  logic     full_q;
  logic     load;

  // Take a new word when empty or when the held one leaves this cycle
  assign in_ready_o = !full_q || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge dst_clk_i) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  // Nothing may be offered downstream as reset is released
  a_quiet_release : assert property (
    @(posedge dst_clk_i) $rose(dst_rst_ni) |-> !out_valid_o
  );

endmodule

/* source/src_spill_reg.sv */
// ----------------------------------------------------------------------
// Two-entry spill register in the source domain
// Sits in front of the FIFO so the upstream ready comes from a flop
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module src_spill_reg (
  input  logic                   src_clk_i,
  input  logic                   src_rst_ni,
  input  cdc_link_pkg::payload_t in_data_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output cdc_link_pkg::payload_t out_data_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i
);

  import cdc_link_pkg::*;

  spill_state_e state_q;
  spill_state_e state_d;
  payload_t     main_q;
  payload_t     spare_q;
  logic         ready_q;
  logic         push;
  logic         pop;

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  // Next fill level from what goes in and out this cycle
  always_comb begin
    state_d = state_q;
    case (state_q)
      SPILL_EMPTY: if (push) state_d = SPILL_ONE;
      SPILL_ONE: begin
        if (push && !pop) begin
          state_d = SPILL_TWO;
        end else if (pop && !push) begin
          state_d = SPILL_EMPTY;
        end
      end
      SPILL_TWO: if (pop) state_d = SPILL_ONE;
      default: state_d = SPILL_EMPTY;
    endcase
  end

  // Ready is registered from the next state so it never waits on the FIFO
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      state_q <= SPILL_EMPTY;
      ready_q <= 1'b1;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d != SPILL_TWO);
    end
  end

  // Main feeds the FIFO and spare catches a word while main is stuck
  always_ff @(posedge src_clk_i) begin
    if (state_q == SPILL_TWO && pop) begin
      main_q <= spare_q;
    end else if (push && (state_q == SPILL_EMPTY || pop)) begin
      main_q <= in_data_i;
    end
    if (push && state_q == SPILL_ONE && !pop) begin
      spare_q <= in_data_i;
    end
  end

  assign in_ready_o  = ready_q;
  assign out_valid_o = (state_q != SPILL_EMPTY);
  assign out_data_o  = main_q;

  // Offered word holds until the FIFO takes it
  a_out_stable : assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
  );

  // The registered ready must never let a word in while both slots are used
  a_no_push_two : assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    push |-> state_q != SPILL_TWO
  );

endmodule

/* verification/tb_cdc_link.sv */
// ----------------------------------------------------------------------
// Directed testbench for the clock-domain-crossing link
// Runs reset, ordering, capacity, random back-pressure and pattern tests
// and checks every output word against a scoreboard queue
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_cdc_link;

  import cdc_link_pkg::*;

  localparam logic [31:0] LFSR_SEED   = 32'hb5b3_9dce;
  localparam logic [31:0] LFSR_POLY   = 32'h8020_0003;
  localparam int          WAIT_LIMIT  = 2000;
  localparam int          STALL_QUIET = 40;

  // How the destination ready is driven
  localparam int READY_LOW    = 0;
  localparam int READY_HIGH   = 1;
  localparam int READY_RANDOM = 2;

  logic     src_clk;
  logic     src_rst_n;
  logic     dst_clk;
  logic     dst_rst_n;
  payload_t src_data;
  logic     src_valid;
  logic     src_ready;
  payload_t dst_data;
  logic     dst_valid;
  logic     dst_ready;

  int          dst_mode;
  logic [31:0] src_lfsr;
  logic [31:0] dst_lfsr;
  payload_t    expected_q[$];
  string       test_name = "none";
  int          error_count = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          recv_count = 0;

  // The two periods do not divide evenly so the edges drift
  tb_clock_gen #(.PERIOD_NS(8.0)) i_src_clk (.clk_o(src_clk), .rst_no(src_rst_n));
  tb_clock_gen #(.PERIOD_NS(12.0)) i_dst_clk (.clk_o(dst_clk), .rst_no(dst_rst_n));

  cdc_link_top UUT (
    .src_clk_i   (src_clk),
    .src_rst_ni  (src_rst_n),
    .src_data_i  (src_data),
    .src_valid_i (src_valid),
    .src_ready_o (src_ready),
    .dst_clk_i   (dst_clk),
    .dst_rst_ni  (dst_rst_n),
    .dst_data_o  (dst_data),
    .dst_valid_o (dst_valid),
    .dst_ready_i (dst_ready)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_POLY;
    end
    return state >> 1;
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits  = {bits[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  task automatic random_payload(output payload_t word);
    logic [31:0] bits;
    draw_bits(src_lfsr, DATA_WIDTH, bits);
    word.data = bits;
    draw_bits(src_lfsr, TAG_WIDTH, bits);
    word.tag = bits[TAG_WIDTH-1:0];
  endtask

  task automatic compare_payload(input string what, input payload_t expected,
                                 input payload_t actual);
    if (actual !== expected) begin
      $display("FAILED %s %s: expected tag %h data %h, actual tag %h data %h",
               test_name, what, expected.tag, expected.data, actual.tag, actual.data);
      error_count++;
    end
  endtask

  task automatic compare_count(input string what, input int expected, input int actual);
    if (actual != expected) begin
      $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic compare_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  // Every accepted output word must match the oldest word sent
  always @(posedge dst_clk) begin : check_output
    payload_t exp_word;
    if (dst_rst_n && dst_valid && dst_ready) begin
      if (expected_q.size() == 0) begin
        $display("%s: output word %h appeared with nothing outstanding", test_name, dst_data);
        error_count++;
      end else begin
        exp_word = expected_q.pop_front();
        compare_payload("output word", exp_word, dst_data);
      end
      recv_count++;
    end
  end

  // Destination ready follows the mode chosen by the running test
  initial begin : drive_dst_ready
    logic [31:0] bits;
    dst_lfsr = LFSR_SEED;
    dst_ready <= 1'b0;
    forever begin
      @(posedge dst_clk);
      if (dst_mode == READY_HIGH) begin
        dst_ready <= 1'b1;
      end else if (dst_mode == READY_RANDOM) begin
        draw_bits(dst_lfsr, 2, bits);
        dst_ready <= (bits[1:0] != 2'b00);
      end else begin
        dst_ready <= 1'b0;
      end
    end
  end

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
    @(posedge src_clk);
  endtask

  task automatic end_test();
    int errs;
    errs = error_count - errors_at_start;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
      $display("%s: done with %0d error(s)", test_name, errs);
    end else begin
      $display("%s: done, ok", test_name);
    end
  endtask

  // Offers one word after some idle cycles and returns at the edge that takes it
  task automatic send_word(input payload_t word, input int gap);
    int waited;
    if (gap > 0) begin
      src_valid <= 1'b0;
      repeat (gap) @(posedge src_clk);
    end
    src_data  <= word;
    src_valid <= 1'b1;
    waited = 0;
    do begin
      @(posedge src_clk);
      waited++;
    end while (!src_ready && waited < WAIT_LIMIT);
    if (src_ready) begin
      expected_q.push_back(word);
    end else begin
      $display("%s: src_ready_o stayed low, word %h never accepted", test_name, word);
      error_count++;
      src_valid <= 1'b0;
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(negedge dst_clk);
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("%s: %0d word(s) never came out", test_name, expected_q.size());
      error_count++;
      expected_q.delete();
    end
    @(posedge src_clk);
  endtask

  task automatic test_reset_state();
    int waited;
    begin_test("reset_state");
    repeat (2) @(posedge src_clk);
    compare_bit("dst_valid_o in reset", 1'b0, dst_valid);
    compare_bit("src_ready_o in reset", 1'b1, src_ready);
    waited = 0;
    while (!(src_rst_n && dst_rst_n) && waited < WAIT_LIMIT) begin
      @(posedge src_clk);
      waited++;
    end
    if (!(src_rst_n && dst_rst_n)) begin
      $display("%s: resets were never released", test_name);
      error_count++;
    end
    repeat (4) @(posedge src_clk);
    compare_bit("dst_valid_o after reset", 1'b0, dst_valid);
    compare_bit("src_ready_o after reset", 1'b1, src_ready);
    end_test();
  endtask

  task automatic test_single_words();
    payload_t word;
    int       recv_start;
    begin_test("single_words");
    dst_mode <= READY_HIGH;
    recv_start = recv_count;
    for (int i = 0; i < 16; i++) begin
      random_payload(word);
      send_word(word, 0);
      src_valid <= 1'b0;
      wait_drained();
    end
    compare_count("words received", 16, recv_count - recv_start);
    end_test();
  endtask

  task automatic test_capacity();
    payload_t word;
    int       accepted;
    int       stalled;
    int       waited;
    int       recv_start;
    begin_test("capacity_stall");
    dst_mode <= READY_LOW;
    waited = 0;
    do begin
      @(negedge dst_clk);
      waited++;
    end while (dst_ready && waited < WAIT_LIMIT);
    @(posedge src_clk);
    accepted = 0;
    stalled  = 0;
    waited   = 0;
    random_payload(word);
    src_data  <= word;
    src_valid <= 1'b1;
    // Keep offering until ready has been low long enough for the pointers to settle
    while (stalled < STALL_QUIET && waited < WAIT_LIMIT) begin
      @(posedge src_clk);
      waited++;
      if (src_ready) begin
        expected_q.push_back(word);
        accepted++;
        stalled = 0;
        random_payload(word);
        src_data <= word;
      end else begin
        stalled++;
      end
    end
    src_valid <= 1'b0;
    if (stalled < STALL_QUIET) begin
      $display("%s: src_ready_o never stayed low under stall", test_name);
      error_count++;
    end
    compare_count("words accepted", LINK_CAPACITY, accepted);
    recv_start = recv_count;
    dst_mode <= READY_HIGH;
    wait_drained();
    compare_count("words drained", accepted, recv_count - recv_start);
    end_test();
  endtask

  task automatic test_random_stream();
    payload_t    word;
    logic [31:0] bits;
    int          recv_start;
    int          recv_done;
    begin_test("random_stream");
    dst_mode <= READY_RANDOM;
    recv_start = recv_count;
    for (int i = 0; i < 200; i++) begin
      random_payload(word);
      draw_bits(src_lfsr, 2, bits);
      send_word(word, int'(bits));
    end
    src_valid <= 1'b0;
    dst_mode  <= READY_HIGH;
    wait_drained();
    compare_count("words received", 200, recv_count - recv_start);
    recv_done = recv_count;
    repeat (50) @(negedge dst_clk);
    compare_count("outputs after drain", recv_done, recv_count);
    end_test();
  endtask

  task automatic test_patterns();
    logic [TAG_WIDTH+DATA_WIDTH-1:0] flat;
    int                              recv_start;
    begin_test("tag_data_patterns");
    dst_mode <= READY_HIGH;
    recv_start = recv_count;
    send_word('1, 0);
    send_word('0, 0);
    // Walking one and walking zero across tag and data together
    for (int i = 0; i < TAG_WIDTH + DATA_WIDTH; i++) begin
      flat    = '0;
      flat[i] = 1'b1;
      send_word(flat, 0);
      send_word(~flat, 0);
    end
    src_valid <= 1'b0;
    wait_drained();
    compare_count("words received", 2 + 2 * (TAG_WIDTH + DATA_WIDTH), recv_count - recv_start);
    end_test();
  endtask

  initial begin
    src_lfsr = LFSR_SEED;
    src_data  <= '0;
    src_valid <= 1'b0;
    dst_mode  <= READY_LOW;
    test_reset_state();
    test_single_words();
    test_capacity();
    test_random_stream();
    test_patterns();
    $display("summary: %0d tests, %0d failed, %0d errors, %0d words out",
             tests_run, tests_failed, error_count, recv_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verification/tb_clock_gen.sv */
// ----------------------------------------------------------------------
// Testbench clock and reset source for one clock domain
// Reset is low from time zero and released after RESET_CYCLES edges
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Release happens on a rising edge like any other driven input
  initial begin
    rst_no <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule
